// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := nco_tb
FILELIST   := nco_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/lfsr_noise.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dither noise source
// free running 15 bit Fibonacci LFSR, taps 15 and 14, low bits as noise
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module lfsr_noise (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	output logic [`NCO_NOISE_W-1:0]      noise
);

	localparam int LFSR_W = 15; // period 2^15-1

	logic [LFSR_W-1:0] lfsr;
	logic              fb;

	assign fb = lfsr[14] ^ lfsr[13]; // x^15 + x^14 + 1

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lfsr <= LFSR_W'(1); // any nonzero seed, all zero would lock up
		else
			lfsr <= {lfsr[LFSR_W-2:0], fb}; // shift left, feedback into bit 0
	end

	assign noise = lfsr[`NCO_NOISE_W-1:0];

endmodule

`default_nettype wire

// ==== design/nco_cmd_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO host command types
// opcode, configuration word and the two-way payload union
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "nco_defs.svh"

package nco_cmd_pkg;

	typedef enum logic [1:0] {
		OP_SET_FREQ  = 2'd0, // payload is the phase increment
		OP_SET_CFG   = 2'd1, // payload is a cfg_t
		OP_CLR_PHASE = 2'd2, // accumulator back to zero
		OP_NOP       = 2'd3
	} opcode_e;

	// configuration view, msb first
	typedef struct packed {
		logic                       dither_en;    // add shifted noise to the phase
		logic                       square_mode;  // square wave instead of sine
		logic [`NCO_SHIFT_W-1:0]    dither_shift; // left shift applied to the noise
		logic [8:0]                 spare;
		logic [`NCO_OFFSET_W-1:0]   phase_offset; // added to the phase msbs
	} cfg_t;

	// same 32 bits, meaning picked by the opcode
	typedef union packed {
		logic [`NCO_PHASE_W-1:0] phase_inc; // OP_SET_FREQ
		cfg_t                    cfg;       // OP_SET_CFG
	} payload_u;

	typedef struct packed {
		opcode_e  opcode;
		payload_u payload;
	} cmd_t;

endpackage

`default_nettype wire

// ==== design/nco_cmd_queue.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO command queue
// four entry FIFO filled under credit flow control, retires one command
// per enabled cycle, decodes it into the held oscillator settings and
// returns a credit pulse one cycle after each retirement
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module nco_cmd_queue (
	input  wire logic                     clk,
	input  wire logic                     arst_n,
	input  wire logic                     cmd_valid,   // one credit spent per cycle high
	input  wire nco_cmd_pkg::cmd_t        cmd_word,
	input  wire logic                     en,          // retire enable
	output logic                          cmd_credit,  // one pulse per retired command
	output nco_sig_pkg::phase_t           phase_inc,
	output logic                          dither_en,
	output logic                          square_mode,
	output logic [`NCO_SHIFT_W-1:0]       dither_shift,
	output logic [`NCO_OFFSET_W-1:0]      phase_offset,
	output logic                          clr_phase    // high in the clear's retirement cycle
);

	localparam int PTR_W = $clog2(`NCO_CMD_DEPTH);
	localparam int CNT_W = $clog2(`NCO_CMD_DEPTH + 1);

	nco_cmd_pkg::cmd_t  mem [`NCO_CMD_DEPTH]; // command storage
	nco_cmd_pkg::cmd_t  head;                 // oldest entry
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;                // entries held, 0..depth
	logic               pop;

	assign head = mem[rd_ptr];
	assign pop  = en && (count != '0); // retire only when enabled and not empty

	// a clear acts in the same cycle it retires, the accumulator loads zero
	assign clr_phase = pop && (head.opcode == nco_cmd_pkg::OP_CLR_PHASE);

	// storage, the credit rule keeps pushes off a full queue
	always_ff @(posedge clk) begin
		if (cmd_valid)
			mem[wr_ptr] <= cmd_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			cmd_credit <= 1'b0;
		end else begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + PTR_W'(1); // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			count      <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
			cmd_credit <= pop; // credit goes back the cycle after retirement
		end
	end

	// held settings, new values take effect after the retirement edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase_inc    <= '0;
			dither_en    <= 1'b0;
			square_mode  <= 1'b0;
			dither_shift <= '0;
			phase_offset <= '0;
		end else if (pop) begin
			case (head.opcode)
				nco_cmd_pkg::OP_SET_FREQ: begin
					phase_inc <= head.payload.phase_inc; // whole word is the increment
				end
				nco_cmd_pkg::OP_SET_CFG: begin
					dither_en    <= head.payload.cfg.dither_en;
					square_mode  <= head.payload.cfg.square_mode;
					dither_shift <= head.payload.cfg.dither_shift;
					phase_offset <= head.payload.cfg.phase_offset;
				end
				default: begin
					// clear and nop leave the settings alone
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/nco_defs.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO widths and depths
// shared by the command packages, the datapath and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef NCO_DEFS_SVH
`define NCO_DEFS_SVH

// phase accumulator and increment width
`define NCO_PHASE_W 32

// phase bits that address one full sine period
`define NCO_LUT_IN_W 10

// signed output sample width
`define NCO_SAMPLE_W 12

// phase offset, lands on the top bits of the phase
`define NCO_OFFSET_W 16

// dither shift field width, covers shifts 0..31
`define NCO_SHIFT_W 5

// command queue entries = credits held by the host after reset
`define NCO_CMD_DEPTH 4

// dither noise width
`define NCO_NOISE_W 4

`endif

// ==== design/nco_phase_acc.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO phase accumulator and dither stage
// accumulates the increment on enabled cycles, then adds the phase offset
// and the shifted noise in a second register that feeds the sine table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module nco_phase_acc (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic                  en,
	input  wire logic                  clr_phase,    // load zero instead of adding
	input  wire nco_sig_pkg::phase_t   phase_inc,
	input  wire logic [`NCO_OFFSET_W-1:0] phase_offset,
	input  wire logic                  dither_en,
	input  wire logic [`NCO_SHIFT_W-1:0]  dither_shift,
	input  wire logic [`NCO_NOISE_W-1:0]  noise,
	output nco_sig_pkg::lut_addr_t     lut_addr,
	output logic                       addr_valid
);

	localparam int PAD_W = `NCO_PHASE_W - `NCO_OFFSET_W;

	nco_sig_pkg::phase_t acc;         // running phase A
	nco_sig_pkg::phase_t dith;        // dithered phase D
	nco_sig_pkg::phase_t offset_term; // offset moved to the msbs
	nco_sig_pkg::phase_t noise_term;
	logic                acc_valid;   // acc was loaded on the last edge

	assign offset_term = {phase_offset, {PAD_W{1'b0}}};

	// noise scaled up, a large shift pushes it into the table address bits
	assign noise_term = dither_en ? (nco_sig_pkg::phase_t'(noise) << dither_shift) : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc        <= '0;
			acc_valid  <= 1'b0;
			addr_valid <= 1'b0;
		end else begin
			acc_valid  <= en;
			addr_valid <= acc_valid; // follows D one edge later
			if (en)
				acc <= clr_phase ? '0 : acc + phase_inc; // modulo 2^32 wrap
		end
	end

	// stage 1, runs every cycle, only addr_valid marks the useful ones
	always_ff @(posedge clk) begin
		dith <= acc + offset_term + noise_term;
	end

	// truncate to the table address
	assign lut_addr = dith[`NCO_PHASE_W-1 -: `NCO_LUT_IN_W];

endmodule

`default_nettype wire

// ==== design/nco_sig_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO datapath signal types
// phase word, sine table address and output sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "nco_defs.svh"

package nco_sig_pkg;

	// unsigned phase, wraps modulo one period
	typedef logic [`NCO_PHASE_W-1:0] phase_t;

	// top phase bits, one full period of the table
	typedef logic [`NCO_LUT_IN_W-1:0] lut_addr_t;

	// two's complement output, symmetric range +-2047
	typedef logic signed [`NCO_SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

// ==== design/nco_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO top level
// command queue, phase accumulator, dither noise and sine table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module nco_top (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              cmd_valid,
	input  wire nco_cmd_pkg::cmd_t cmd_word,
	input  wire logic              en,          // sample enable
	output logic                   cmd_credit,
	output nco_sig_pkg::sample_t   sample,
	output logic                   sample_valid
);

	nco_sig_pkg::phase_t          phase_inc;
	logic                         dither_en;
	logic                         square_mode;
	logic [`NCO_SHIFT_W-1:0]      dither_shift;
	logic [`NCO_OFFSET_W-1:0]     phase_offset;
	logic                         clr_phase;
	logic [`NCO_NOISE_W-1:0]      noise;
	nco_sig_pkg::lut_addr_t       lut_addr;
	logic                         addr_valid;

	nco_cmd_queue i_nco_cmd_queue (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd_word     (cmd_word),
		.en           (en),
		.cmd_credit   (cmd_credit),
		.phase_inc    (phase_inc),
		.dither_en    (dither_en),
		.square_mode  (square_mode),
		.dither_shift (dither_shift),
		.phase_offset (phase_offset),
		.clr_phase    (clr_phase)
	);

	lfsr_noise i_lfsr_noise (
		.clk    (clk),
		.arst_n (arst_n),
		.noise  (noise)
	);

	nco_phase_acc i_nco_phase_acc (
		.clk          (clk),
		.arst_n       (arst_n),
		.en           (en),
		.clr_phase    (clr_phase),
		.phase_inc    (phase_inc),
		.phase_offset (phase_offset),
		.dither_en    (dither_en),
		.dither_shift (dither_shift),
		.noise        (noise),
		.lut_addr     (lut_addr),
		.addr_valid   (addr_valid)
	);

	sine_lut i_sine_lut (
		.clk          (clk),
		.arst_n       (arst_n),
		.lut_addr     (lut_addr),
		.addr_valid   (addr_valid),
		.square_mode  (square_mode),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

endmodule

`default_nettype wire

// ==== design/sine_lut.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Quarter wave sine table
// first quadrant built at elaboration, other quadrants by folding the
// address and negating; square mode gives full scale by the sign bit.
// output registered
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module sine_lut (
	input  wire logic                   clk,
	input  wire logic                   arst_n,
	input  wire nco_sig_pkg::lut_addr_t lut_addr,
	input  wire logic                   addr_valid,
	input  wire logic                   square_mode,
	output nco_sig_pkg::sample_t        sample,
	output logic                        sample_valid
);

	localparam int QW      = `NCO_LUT_IN_W - 2;  // quadrant index bits
	localparam int QUARTER = 2 ** QW;            // 256 entries
	localparam int MAG_W   = `NCO_SAMPLE_W - 1;  // magnitude, sign added later
	localparam logic [MAG_W-1:0] FULL = '1;      // 2047
	localparam real  PI    = 3.14159265358979323846;

	typedef logic [QUARTER-1:0][MAG_W-1:0] quarter_t;

	// round(2047 * sin(2*pi*i/1024)) for the first quadrant
	function automatic quarter_t build_quarter();
		quarter_t t;
		real      ang;
		for (int i = 0; i < QUARTER; i++) begin
			ang  = 2.0 * PI * real'(i) / real'(4 * QUARTER);
			t[i] = MAG_W'($rtoi(real'(FULL) * $sin(ang) + 0.5)); // all >= 0, half up
		end
		return t;
	endfunction

	localparam quarter_t QTAB = build_quarter();

	logic [1:0]           quad;    // which quarter of the period
	logic [QW-1:0]        k;       // offset inside the quarter
	logic [QW:0]          idx;     // folded index, 0..256
	logic [MAG_W-1:0]     mag;
	logic [MAG_W-1:0]     mag_sel;
	nco_sig_pkg::sample_t pos;
	nco_sig_pkg::sample_t result;

	assign quad = lut_addr[`NCO_LUT_IN_W-1 -: 2];
	assign k    = lut_addr[QW-1:0];

	// quadrants 1 and 3 run backwards, sin(pi/2 + x) = sin(pi/2 - x)
	assign idx = quad[0] ? ((QW+1)'(QUARTER) - {1'b0, k}) : {1'b0, k};

	// index 256 is the peak, one past the stored quadrant
	assign mag = idx[QW] ? FULL : QTAB[idx[QW-1:0]];

	assign mag_sel = square_mode ? FULL : mag; // square wave is always full scale
	assign pos     = nco_sig_pkg::sample_t'(mag_sel);      // zero extend, positive
	assign result  = quad[1] ? -pos : pos;     // second half period is negative

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sample_valid <= 1'b0;
		else
			sample_valid <= addr_valid;
	end

	// sample holds its last value between valid cycles
	always_ff @(posedge clk) begin
		if (addr_valid)
			sample <= result;
	end

endmodule

`default_nettype wire

// ==== nco_top.f ====
+incdir+design
design/nco_cmd_pkg.sv
design/nco_sig_pkg.sv
design/lfsr_noise.sv
design/nco_cmd_queue.sv
design/nco_phase_acc.sv
design/sine_lut.sv
design/nco_top.sv
tb/nco_checker.sv
tb/nco_tb.sv

// ==== tb/nco_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO command queue checker
// flow control properties of the credit queue, bound into the queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module nco_checker (
	input wire logic                                   clk,
	input wire logic                                   arst_n,
	input wire logic                                   en,
	input wire logic                                   cmd_valid,
	input wire logic                                   pop,    // retirement this cycle
	input wire logic [$clog2(`NCO_CMD_DEPTH + 1)-1:0]  count,  // entries held
	input wire logic                                   cmd_credit
);

	int fail_cnt = 0; // assertion failures so far

	// host holds no credit while all entries are taken
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> (count < `NCO_CMD_DEPTH))
		else begin
			fail_cnt++;
			$error("command pushed into a full queue");
		end

	// every credit pulse pays back one retirement
	a_credit_after_pop: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_credit |-> $past(pop))
		else begin
			fail_cnt++;
			$error("credit pulse without a retirement one cycle before");
		end

	// a stalled cycle retires nothing so no credit follows it
	a_no_credit_after_stall: assert property (@(posedge clk) disable iff (!arst_n)
		!en |=> !cmd_credit)
		else begin
			fail_cnt++;
			$error("credit pulse after a stalled cycle");
		end

endmodule

`default_nettype wire

// ==== tb/nco_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NCO testbench
// random commands under credit flow control and a random sample enable,
// checked against a cycle model of queue, accumulator, dither and table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "nco_defs.svh"

module nco_tb;

	localparam int  PERIOD    = 40;
	localparam int  RST_CYC   = 8;
	localparam int  PHASE_CYC = 600; // freq, offset and clear, dither, square, stalls
	localparam int  N_PHASES  = 5;
	localparam int  DRAIN_CYC = 40;
	localparam int  TEST_CYC  = RST_CYC + N_PHASES * PHASE_CYC + DRAIN_CYC;
	localparam real PI        = 3.141592653589793;

	logic                 clk = 1'b0;
	logic                 arst_n;
	logic                 cmd_valid;
	logic                 en;
	nco_cmd_pkg::cmd_t    cmd_word;
	logic                 cmd_credit;
	nco_sig_pkg::sample_t sample;
	logic                 sample_valid;

	int credits;      // credits the host holds
	int sent;
	int returned;     // credit pulses seen

	// model state stepped on the rising edge
	nco_cmd_pkg::cmd_t   m_q[$];
	nco_cmd_pkg::cfg_t   m_cfg;
	nco_sig_pkg::phase_t m_inc;
	nco_sig_pkg::phase_t m_acc;
	nco_sig_pkg::phase_t m_dith;
	logic [14:0]         m_lfsr;
	logic                m_acc_valid;
	logic                m_addr_valid;
	logic                m_sample_valid;
	logic                m_credit;
	int                  m_sample;
	logic [2:0]          en_hist; // en of the last three cycles

	always #(PERIOD / 2) clk = ~clk;

	nco_top i_nco_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd_word     (cmd_word),
		.en           (en),
		.cmd_credit   (cmd_credit),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	bind nco_cmd_queue nco_checker i_nco_checker (
		.clk        (clk),
		.arst_n     (arst_n),
		.en         (en),
		.cmd_valid  (cmd_valid),
		.pop        (pop),
		.count      (count),
		.cmd_credit (cmd_credit)
	);

	// round(2047 sin(2 pi a / 1024)) or full scale by the top bit
	function automatic int expected_sample(input logic [9:0] addr, input logic square);
		real v;
		if (square)
			return addr[9] ? -2047 : 2047;
		v = 2047.0 * $sin(2.0 * PI * real'(addr) / 1024.0);
		return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v); // half away from zero
	endfunction

	function automatic nco_cmd_pkg::cmd_t random_cmd(input int mode);
		nco_cmd_pkg::cmd_t c;
		c.opcode            = nco_cmd_pkg::opcode_e'($urandom_range(3));
		c.payload.phase_inc = $urandom;
		if (mode == 0 && c.opcode == nco_cmd_pkg::OP_CLR_PHASE)
			c.opcode = nco_cmd_pkg::OP_SET_FREQ; // first phase keeps the phase running
		if (c.opcode == nco_cmd_pkg::OP_SET_CFG) begin
			case (mode)
				0: c.payload.cfg = '0; // plain sine, zero offset
				1: begin
					c.payload.cfg.dither_en   = 1'b0; // offset only
					c.payload.cfg.square_mode = 1'b0;
				end
				2: begin
					c.payload.cfg.dither_en   = 1'b1; // random shift and offset
					c.payload.cfg.square_mode = 1'b0;
				end
				3: c.payload.cfg.square_mode = 1'b1;
				default: ;
			endcase
		end
		return c;
	endfunction

	always @(posedge clk) begin : model
		logic                pop;
		logic                clr;
		nco_cmd_pkg::cmd_t   head;
		nco_sig_pkg::phase_t nterm;
		if (!arst_n) begin
			m_q.delete();
			m_cfg          = '0;
			m_inc          = '0;
			m_acc          = '0;
			m_dith         = '0;
			m_lfsr         = 15'h0001;
			m_acc_valid    = 1'b0;
			m_addr_valid   = 1'b0;
			m_sample_valid = 1'b0;
			m_credit       = 1'b0;
			en_hist        = '0;
		end else begin
			pop   = en && (m_q.size() != 0);
			head  = pop ? m_q[0] : '0;
			clr   = pop && (head.opcode == nco_cmd_pkg::OP_CLR_PHASE);
			nterm = m_cfg.dither_en ?
				(nco_sig_pkg::phase_t'(m_lfsr[3:0]) << m_cfg.dither_shift) : '0;
			// table stage sees last cycle's address and mode
			m_sample_valid = m_addr_valid;
			if (m_addr_valid)
				m_sample = expected_sample(m_dith[`NCO_PHASE_W-1 -: `NCO_LUT_IN_W],
					m_cfg.square_mode);
			m_addr_valid = m_acc_valid;
			m_dith       = m_acc + {m_cfg.phase_offset, 16'h0000} + nterm;
			m_acc_valid  = en;
			if (en)
				m_acc = clr ? '0 : m_acc + m_inc; // old increment in the retire cycle
			m_credit = pop;
			if (pop) begin
				if (head.opcode == nco_cmd_pkg::OP_SET_FREQ)
					m_inc = head.payload.phase_inc;
				else if (head.opcode == nco_cmd_pkg::OP_SET_CFG)
					m_cfg = head.payload.cfg;
				void'(m_q.pop_front());
			end
			if (cmd_valid)
				m_q.push_back(cmd_word);
			m_lfsr  = {m_lfsr[13:0], m_lfsr[14] ^ m_lfsr[13]};
			en_hist = {en_hist[1:0], en};
		end
	end

	task automatic fail_now();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	// outputs are stable at the falling edge
	task automatic check_outputs();
		assert (cmd_credit === m_credit) else begin
			$display("error at %0t ns: cmd_credit expected %0b actual %0b", $time,
				m_credit, cmd_credit);
			fail_now();
		end
		assert (sample_valid === m_sample_valid) else begin
			$display("error at %0t ns: sample_valid expected %0b actual %0b", $time,
				m_sample_valid, sample_valid);
			fail_now();
		end
		if (m_sample_valid)
			assert (int'(sample) == m_sample) else begin
				$display("error at %0t ns: sample expected %0d actual %0d", $time, m_sample,
					int'(sample));
				fail_now();
			end
		if (en_hist == 3'b000)
			assert (!sample_valid) else begin
				$display("sample_valid came out after three stalled cycles");
				fail_now();
			end
	endtask

	// one clock cycle with inputs changed on the falling edge
	task automatic run_cycle(input int mode, input int en_pct, input bit may_send);
		@(negedge clk);
		check_outputs();
		if (cmd_credit) begin
			credits++;
			returned++;
		end
		en        = ($urandom_range(99) < en_pct);
		cmd_valid = may_send && (credits > 0) && ($urandom_range(99) < 60);
		cmd_word  = cmd_valid ? random_cmd(mode) : '0;
		if (cmd_valid) begin
			credits--;
			sent++;
		end
	endtask

	initial begin : watchdog
		#((TEST_CYC + 200) * PERIOD);
		$display("timeout, the run did not finish");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(32'hfc31c260));
		arst_n    = 1'b0;
		cmd_valid = 1'b0;
		cmd_word  = '0;
		en        = 1'b0;
		credits   = `NCO_CMD_DEPTH;
		sent      = 0;
		returned  = 0;
		repeat (RST_CYC) begin
			@(negedge clk);
			assert (!cmd_credit && !sample_valid) else begin
				$display("cmd_credit or sample_valid rose while reset was held");
				fail_now();
			end
		end
		arst_n = 1'b1; // released on a falling edge
		for (int m = 0; m < N_PHASES - 1; m++)
			repeat (PHASE_CYC) run_cycle(m, 70, 1'b1);
		repeat (PHASE_CYC / 60) begin
			repeat (40) run_cycle(4, 0, 1'b1); // long stall
			assert (credits == 0) else begin
				$display("host still holds credits after a long stall");
				fail_now();
			end
			repeat (20) run_cycle(4, 70, 1'b1);
		end
		repeat (DRAIN_CYC) run_cycle(0, 100, 1'b0); // queue empties and the credits come home
		assert (returned == sent && credits == `NCO_CMD_DEPTH) else begin
			$display("error at %0t ns: credit pulses expected %0d actual %0d", $time,
				sent, returned);
			fail_now();
		end
		if (i_nco_top.i_nco_cmd_queue.i_nco_checker.fail_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "flow control assertions failed");
		end
	end

endmodule

`default_nettype wire
